// File: cmd_decoder.sv
`timescale 1ns/1ps
`include "pdu_dbg_params.svh"

module cmd_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  pdu_dbg_pkg::rx_byte_t    byte_in,
    output logic                     ready,
    input  pdu_dbg_pkg::cpu_status_t cpu_status,
    output logic                     run_en,
    output logic                     cpu_rst,
    output pdu_dbg_pkg::pdu_word_t   check_addr,
    output pdu_dbg_pkg::print_req_t  print_req,
    input  logic                     tx_busy
);
    import pdu_dbg_pkg::*;

    typedef enum logic [4:0] {
        S_IDLE,
        S_S, S_ST, S_STE, S_STEP, S_STEP_LOAD,
        S_R, S_RU, S_RUN_CMD, S_RUN,
        S_RS, S_RST_CMD, S_RST_DONE,
        S_C, S_CH, S_CK, S_CHK_HEX,
        S_B, S_BP_HEX,
        S_PRINT, S_PRINT_WAIT
    } state_t;

    state_t     state;
    state_t     state_d;
    pdu_word_t  bp_addr;
    pdu_word_t  hex_acc;
    pdu_word_t  sel_base;
    pdu_word_t  chk_target;
    pdu_word_t  print_word;
    logic       take;
    logic       is_end;
    logic       stop;
    logic [4:0] hex_nib;

    // Returns {is_hex, nibble}
    function automatic logic [4:0] hex_decode(input pdu_char_t ch);
        logic [4:0] res;
        res = 5'h00;
        if (ch >= "0" && ch <= "9")
            res = {1'b1, 4'(ch - "0")};
        else if (ch >= "a" && ch <= "f")
            res = {1'b1, 4'(ch - "a" + 8'd10)};
        return res;
    endfunction

    assign take       = byte_in.valid && ready;
    assign is_end     = take && (byte_in.data == ";");
    assign hex_nib    = hex_decode(byte_in.data);
    assign chk_target = sel_base + hex_acc;

    assign stop = (cpu_status.current_pc == bp_addr)
               || (cpu_status.current_pc < `PDU_PC_LO)
               || (cpu_status.current_pc > `PDU_PC_HI);

    assign ready  = !(state inside {S_STEP_LOAD, S_RUN, S_RST_DONE, S_PRINT, S_PRINT_WAIT});
    assign run_en = (state == S_RUN) && !stop;
    assign print_req = '{valid: (state == S_PRINT) && !tx_busy, value: print_word};

    always_comb begin
        state_d = state;
        case (state)
            S_IDLE: if (take) begin
                case (byte_in.data)
                    "s": state_d = S_S;
                    "r": state_d = S_R;
                    "c": state_d = S_C;
                    "b": state_d = S_B;
                    default: state_d = S_IDLE;
                endcase
            end
            S_S:       if (take) state_d = (byte_in.data == "t") ? S_ST : S_IDLE;
            S_ST:      if (take) state_d = (byte_in.data == "e") ? S_STE : S_IDLE;
            S_STE:     if (take) state_d = (byte_in.data == "p") ? S_STEP : S_IDLE;
            S_STEP:    if (take) state_d = (byte_in.data == ";") ? S_STEP_LOAD : S_IDLE;
            S_R: if (take) begin
                case (byte_in.data)
                    "u": state_d = S_RU;
                    "s": state_d = S_RS;
                    default: state_d = S_IDLE;
                endcase
            end
            S_RU:      if (take) state_d = (byte_in.data == "n") ? S_RUN_CMD : S_IDLE;
            S_RUN_CMD: if (take) state_d = (byte_in.data == ";") ? S_RUN : S_IDLE;
            S_RS:      if (take) state_d = (byte_in.data == "t") ? S_RST_CMD : S_IDLE;
            S_RST_CMD: if (take) state_d = (byte_in.data == ";") ? S_RST_DONE : S_IDLE;
            S_C:       if (take) state_d = (byte_in.data == "h") ? S_CH : S_IDLE;
            S_CH:      if (take) state_d = (byte_in.data == "k") ? S_CK : S_IDLE;
            S_CK: if (take) begin
                case (byte_in.data)
                    " ", "1", "2": state_d = S_CHK_HEX;
                    default: state_d = S_IDLE;
                endcase
            end
            S_B:       if (take) state_d = (byte_in.data == "p") ? S_BP_HEX : S_IDLE;
            S_CHK_HEX, S_BP_HEX: if (is_end) state_d = S_PRINT;
            S_STEP_LOAD:  state_d = S_RUN;
            S_RUN:        if (stop) state_d = S_IDLE;
            S_RST_DONE:   state_d = S_IDLE;
            S_PRINT:      if (!tx_busy) state_d = S_PRINT_WAIT;
            S_PRINT_WAIT: if (!tx_busy) state_d = S_IDLE;
            default:      state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            bp_addr    <= '0;
            check_addr <= '0;
            cpu_rst    <= 1'b0;
        end else begin
            state   <= state_d;
            cpu_rst <= (state == S_RST_DONE);
            // Single step runs to the next instruction
            if (state == S_STEP_LOAD)
                bp_addr <= cpu_status.next_pc;
            else if (is_end && state == S_BP_HEX)
                bp_addr <= hex_acc;
            if (is_end && state == S_CHK_HEX)
                check_addr <= chk_target;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (state == S_B || state == S_CK)
                hex_acc <= '0;
            else if ((state == S_BP_HEX || state == S_CHK_HEX) && hex_nib[4])
                hex_acc <= {hex_acc[`PDU_WORD_W-5:0], hex_nib[3:0]};
            if (state == S_CK) begin
                case (byte_in.data)
                    "1": sel_base <= `PDU_RF_BASE;
                    "2": sel_base <= `PDU_DM_BASE;
                    default: sel_base <= '0;
                endcase
            end
            if (is_end && state == S_BP_HEX)
                print_word <= hex_acc;
            else if (is_end && state == S_CHK_HEX)
                print_word <= chk_target;
        end
    end

    // hex_tx must answer every request with busy
    a_print_handshake: assert property (@(posedge clk) disable iff (rst)
        print_req.valid |=> tx_busy);

endmodule

// File: cmd_rx.sv
`timescale 1ns/1ps

module cmd_rx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   din_req,
    input  pdu_dbg_pkg::pdu_char_t din_data,
    output logic                   din_ack,
    output pdu_dbg_pkg::rx_byte_t  byte_out,
    input  logic                   ready
);
    import pdu_dbg_pkg::*;

    logic      pending;
    logic      new_req;
    pdu_char_t data_q;

    // Request is only new once the last acknowledge is released
    assign new_req = din_req && !pending && !din_ack;
    assign byte_out = '{valid: pending, data: data_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            din_ack <= 1'b0;
        end else begin
            if (pending) begin
                if (ready) begin
                    pending <= 1'b0;
                    din_ack <= 1'b1;
                end
            end else if (din_ack) begin
                if (!din_req) begin
                    din_ack <= 1'b0;
                end
            end else if (din_req) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_req) begin
            data_q <= din_data;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(din_ack) |-> din_req);

endmodule

// File: cpu_clk_gen.sv
`timescale 1ns/1ps
`include "pdu_dbg_params.svh"

module cpu_clk_gen (
    input  logic clk,
    input  logic rst,
    input  logic run_en,
    output logic cpu_clk
);
    localparam int HALF  = `PDU_CPU_CLK_HALF;
    localparam int CNT_W = $clog2(2 * HALF + 1);
    localparam logic [CNT_W-1:0] PERIOD   = CNT_W'(2 * HALF);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(HALF);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_d;

    // Zero is idle and a new period only starts from idle or the end of one
    always_comb begin
        if (cnt == '0 || cnt == PERIOD)
            cnt_d = run_en ? CNT_W'(1) : '0;
        else
            cnt_d = cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            cpu_clk <= 1'b0;
        end else begin
            cnt     <= cnt_d;
            // High for the first half of the period
            cpu_clk <= (cnt_d != '0) && (cnt_d <= HALF_CNT);
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        cnt <= PERIOD);

endmodule

// File: hex_tx.sv
`timescale 1ns/1ps
`include "pdu_dbg_params.svh"

module hex_tx (
    input  logic                    clk,
    input  logic                    rst,
    input  pdu_dbg_pkg::print_req_t print_req,
    output logic                    tx_busy,
    output logic                    dout_req,
    output pdu_dbg_pkg::pdu_char_t  dout_data,
    input  logic                    dout_ack
);
    import pdu_dbg_pkg::*;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_LOAD,
        TX_REQ,
        TX_REL
    } tx_state_t;

    // Eight digits then the newline
    localparam logic [3:0] LAST_IDX = 4'd8;

    tx_state_t  state;
    pdu_word_t  word_q;
    logic [3:0] idx;
    logic [3:0] nib;

    assign tx_busy = (state != TX_IDLE);
    assign nib     = word_q[`PDU_WORD_W-1 -: 4];

    always_comb begin
        if (idx == LAST_IDX)
            dout_data = pdu_char_t'("\n");
        else if (nib < 4'd10)
            dout_data = pdu_char_t'("0") + pdu_char_t'(nib);
        else
            dout_data = pdu_char_t'("a") + pdu_char_t'(nib) - pdu_char_t'(10);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            dout_req <= 1'b0;
            idx      <= '0;
        end else begin
            case (state)
                TX_IDLE: if (print_req.valid) begin
                    idx   <= '0;
                    state <= TX_LOAD;
                end
                // Character settles one cycle before the request
                TX_LOAD: begin
                    dout_req <= 1'b1;
                    state    <= TX_REQ;
                end
                TX_REQ: if (dout_ack) begin
                    dout_req <= 1'b0;
                    state    <= TX_REL;
                end
                TX_REL: if (!dout_ack) begin
                    if (idx == LAST_IDX) begin
                        state <= TX_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= TX_LOAD;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Most significant nibble always sits on top
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && print_req.valid)
            word_q <= print_req.value;
        else if (state == TX_REL && !dout_ack && idx != LAST_IDX)
            word_q <= word_q << 4;
    end

    a_data_stable: assert property (@(posedge clk) disable iff (rst)
        dout_req |-> $stable(dout_data));

endmodule

// File: pdu_dbg.f
+incdir+.
pdu_dbg_pkg.sv
cmd_rx.sv
cmd_decoder.sv
cpu_clk_gen.sv
hex_tx.sv
pdu_dbg_top.sv
tb_pdu_dbg.sv

// File: pdu_dbg_params.svh
`ifndef PDU_DBG_PARAMS_SVH
`define PDU_DBG_PARAMS_SVH

// Data widths
`define PDU_WORD_W 32
`define PDU_CHAR_W 8

// Check address window bases
`define PDU_RF_BASE 32'h0000_1000
`define PDU_DM_BASE 32'h0000_2000

// Legal program window for the run command
`define PDU_PC_LO 32'h0000_2ff0
`define PDU_PC_HI 32'h0000_3fff

// System cycles per CPU clock half period
`define PDU_CPU_CLK_HALF 5

`endif

// File: pdu_dbg_pkg.sv
`include "pdu_dbg_params.svh"

package pdu_dbg_pkg;

    typedef logic [`PDU_WORD_W-1:0] pdu_word_t;
    typedef logic [`PDU_CHAR_W-1:0] pdu_char_t;

    // One received character handed to the parser
    typedef struct packed {
        logic      valid;
        pdu_char_t data;
    } rx_byte_t;

    // Word to be printed as hex text
    typedef struct packed {
        logic      valid;
        pdu_word_t value;
    } print_req_t;

    typedef struct packed {
        pdu_word_t current_pc;
        pdu_word_t next_pc;
    } cpu_status_t;

endpackage

// File: pdu_dbg_top.sv
`timescale 1ns/1ps

module pdu_dbg_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     din_req,
    input  pdu_dbg_pkg::pdu_char_t   din_data,
    output logic                     din_ack,
    output logic                     dout_req,
    output pdu_dbg_pkg::pdu_char_t   dout_data,
    input  logic                     dout_ack,
    input  pdu_dbg_pkg::cpu_status_t cpu_status,
    output logic                     cpu_clk,
    output logic                     cpu_rst,
    output pdu_dbg_pkg::pdu_word_t   check_addr
);
    import pdu_dbg_pkg::*;

    rx_byte_t   rx_byte;
    logic       rx_ready;
    print_req_t print_req;
    logic       tx_busy;
    logic       run_en;

    cmd_rx rx_i (
        .clk      (clk),
        .rst      (rst),
        .din_req  (din_req),
        .din_data (din_data),
        .din_ack  (din_ack),
        .byte_out (rx_byte),
        .ready    (rx_ready)
    );

    cmd_decoder dec_i (
        .clk        (clk),
        .rst        (rst),
        .byte_in    (rx_byte),
        .ready      (rx_ready),
        .cpu_status (cpu_status),
        .run_en     (run_en),
        .cpu_rst    (cpu_rst),
        .check_addr (check_addr),
        .print_req  (print_req),
        .tx_busy    (tx_busy)
    );

    cpu_clk_gen clk_gen_i (
        .clk     (clk),
        .rst     (rst),
        .run_en  (run_en),
        .cpu_clk (cpu_clk)
    );

    hex_tx tx_i (
        .clk       (clk),
        .rst       (rst),
        .print_req (print_req),
        .tx_busy   (tx_busy),
        .dout_req  (dout_req),
        .dout_data (dout_data),
        .dout_ack  (dout_ack)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f pdu_dbg.f \
    --top-module tb_pdu_dbg -o tb_pdu_dbg > "$LOG" 2>&1 \
    && ./obj_dir/tb_pdu_dbg >> "$LOG" 2>&1 \
    || { cat "$LOG"; echo "build or simulation failed"; exit 1; }

cat "$LOG"
grep -q "FAIL: see errors above" "$LOG" && exit 1 || exit 0

// File: tb_pdu_dbg.sv
`timescale 1ns/1ps
`include "pdu_dbg_params.svh"

module tb_pdu_dbg;
    import pdu_dbg_pkg::*;

    typedef pdu_char_t [8:0] text_t;

    localparam int CPU_PERIODS = 5;

    logic        clk;
    logic        rst;
    logic        din_req;
    pdu_char_t   din_data;
    logic        din_ack;
    logic        dout_req;
    pdu_char_t   dout_data;
    logic        dout_ack;
    cpu_status_t cpu_status;
    logic        cpu_clk;
    logic        cpu_rst;
    pdu_word_t   check_addr;

    pdu_word_t   model_pc = 32'h3000;
    logic        cpu_clk_q = 1'b0;
    logic        cpu_rst_q = 1'b0;
    int          clk_edges = 0;
    int          rst_pulses = 0;
    int          out_chars = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    pdu_char_t   exp_q[$];

    // Commands of the whole run set the watchdog limit
    string all_cmds[9] = '{"chk1 1f;", "chk2a;", "chk 3c;", "bp3010;", "run;",
                           "step;", "rst;", "cxk;", "bp3008;"};

    pdu_dbg_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .din_req    (din_req),
        .din_data   (din_data),
        .din_ack    (din_ack),
        .dout_req   (dout_req),
        .dout_data  (dout_data),
        .dout_ack   (dout_ack),
        .cpu_status (cpu_status),
        .cpu_clk    (cpu_clk),
        .cpu_rst    (cpu_rst),
        .check_addr (check_addr)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // CPU model with one instruction per rising cpu_clk
    always @(posedge clk) begin
        pdu_word_t pc_n;
        pc_n = model_pc;
        if (rst || cpu_rst)
            pc_n = 32'h3000;
        else if (cpu_clk && !cpu_clk_q)
            pc_n = model_pc + 32'd4;
        if (cpu_clk && !cpu_clk_q)
            clk_edges <= clk_edges + 1;
        if (cpu_rst && !cpu_rst_q)
            rst_pulses <= rst_pulses + 1;
        model_pc   <= pc_n;
        cpu_status <= '{current_pc: pc_n, next_pc: pc_n + 32'd4};
        cpu_clk_q  <= cpu_clk;
        cpu_rst_q  <= cpu_rst;
    end

    function automatic text_t expected_text(input pdu_word_t w);
        text_t      t;
        logic [3:0] nib;
        for (int i = 0; i < 8; i++) begin
            nib = w[31 - 4 * i -: 4];
            // Lowercase ASCII digits start at 0x30 and letters at 0x61
            if (nib < 4'd10)
                t[8 - i] = 8'h30 + 8'(nib);
            else
                t[8 - i] = 8'h61 + 8'(nib) - 8'd10;
        end
        t[0] = 8'h0a;
        return t;
    endfunction

    task automatic check_word(input string name, input pdu_word_t exp, input pdu_word_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_char(input string name, input pdu_char_t exp, input pdu_char_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // Output link model that compares each character as it arrives
    initial begin
        dout_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (dout_req && !dout_ack) begin
                out_chars++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected output character %h at %0t", dout_data, $time);
                    errors++;
                end else begin
                    check_char("dout_data", exp_q.pop_front(), dout_data);
                end
                repeat ($urandom % 4) @(posedge clk);
                dout_ack <= 1'b1;
                do @(posedge clk); while (dout_req);
                repeat ($urandom % 4) @(posedge clk);
                dout_ack <= 1'b0;
            end
        end
    end

    task automatic send_char(input pdu_char_t c);
        repeat ($urandom % 4) @(posedge clk);
        din_data <= c;
        @(posedge clk);
        din_req <= 1'b1;
        do @(posedge clk); while (!din_ack);
        repeat ($urandom % 4) @(posedge clk);
        din_req <= 1'b0;
        do @(posedge clk); while (din_ack);
    endtask

    task automatic send_cmd(input string cmd);
        for (int i = 0; i < cmd.len(); i++)
            send_char(cmd[i]);
    endtask

    // Idle means parser ready, printer and CPU clock quiet
    task automatic wait_idle();
        do @(posedge clk);
        while (!(dut_i.rx_ready && !dut_i.tx_busy && dut_i.clk_gen_i.cnt == '0
                 && !cpu_rst && exp_q.size() == 0));
        repeat (2) @(posedge clk);
    endtask

    task automatic run_print(input string cmd, input pdu_word_t value);
        text_t t;
        t = expected_text(value);
        for (int i = 8; i >= 0; i--)
            exp_q.push_back(t[i]);
        send_cmd(cmd);
        wait_idle();
    endtask

    task automatic run_silent(input string cmd, input int exp_edges, input int exp_resets);
        int edges0;
        int resets0;
        int chars0;
        edges0  = clk_edges;
        resets0 = rst_pulses;
        chars0  = out_chars;
        send_cmd(cmd);
        wait_idle();
        check_count("cpu_clk edges", exp_edges, clk_edges - edges0);
        check_count("cpu_rst pulses", exp_resets, rst_pulses - resets0);
        check_count("output chars", 0, out_chars - chars0);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            failed++;
            $display("test %0d %s: failed", tests, name);
        end else begin
            $display("test %0d %s: ok", tests, name);
        end
    endtask

    initial begin
        int limit;
        limit = 2000 + CPU_PERIODS * 2 * `PDU_CPU_CLK_HALF * 2;
        foreach (all_cmds[i])
            limit += all_cmds[i].len() * 40;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int e;
        void'($urandom(79145));
        rst        = 1'b1;
        din_req    = 1'b0;
        din_data   = '0;
        cpu_status = '{current_pc: 32'h3000, next_pc: 32'h3004};
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        e = errors;
        run_print("chk1 1f;", `PDU_RF_BASE + 32'h1f);
        check_word("check_addr", `PDU_RF_BASE + 32'h1f, check_addr);
        run_print("chk2a;", `PDU_DM_BASE + 32'h0a);
        check_word("check_addr", `PDU_DM_BASE + 32'h0a, check_addr);
        run_print("chk 3c;", 32'h3c);
        check_word("check_addr", 32'h3c, check_addr);
        report_test("chk address print", e);

        e = errors;
        run_print("bp3010;", 32'h3010);
        report_test("bp print", e);

        e = errors;
        run_silent("run;", (32'h3010 - 32'h3000) / 4, 0);
        check_word("model_pc", 32'h3010, model_pc);
        report_test("run to breakpoint", e);

        e = errors;
        run_silent("step;", 1, 0);
        check_word("model_pc", 32'h3014, model_pc);
        report_test("single step", e);

        e = errors;
        run_silent("rst;", 0, 1);
        check_word("model_pc", 32'h3000, model_pc);
        report_test("cpu reset", e);

        e = errors;
        run_silent("cxk;", 0, 0);
        run_print("bp3008;", 32'h3008);
        report_test("invalid command ignored", e);

        $display("tests: %0d, failed: %0d, errors: %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
